/* source/rv_pkg.sv */
`default_nettype none

package rv_pkg;

  localparam int xlen = 32;

  typedef logic [xlen-1:0] word_t;
  typedef logic [4:0]      reg_addr_t;

  localparam logic [6:0] op_reg    = 7'b0110011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_system = 7'b1110011;

  localparam reg_addr_t halt_reg  = 5'd17;  // a7 carries the exit request
  localparam word_t     halt_code = 32'd10; // exit service number

  typedef enum logic [3:0] {
    alu_add, // zero so a bubble decodes as add
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_sll,
    alu_srl,
    alu_sra,
    alu_slt
  } alu_op_e;

  typedef struct packed {
    logic reg_write;
    logic mem_read;
    logic mem_write;
    logic alu_src_imm; // second alu operand from imm
    logic is_branch;
    logic is_jal;
    logic is_jalr;
    logic link;        // result is pc + 4
    logic halt;
  } ctrl_t;

  typedef struct packed {
    word_t pc;
    word_t instr;
  } if_id_t;

  typedef struct packed {
    ctrl_t      ctrl;
    alu_op_e    alu_op;
    logic [2:0] funct3; // branch compare select
    word_t      pc;
    word_t      rs1_data;
    word_t      rs2_data;
    word_t      imm;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    reg_addr_t  rd;
  } id_ex_t;

  typedef struct packed {
    logic      reg_write;
    logic      mem_read;
    logic      mem_write;
    logic      halt;
    word_t     result;     // alu or link value, also the data address
    word_t     store_data;
    reg_addr_t rd;
  } ex_mem_t;

  typedef struct packed {
    logic      reg_write;
    logic      halt;
    word_t     wdata;
    reg_addr_t rd;
  } mem_wb_t;

endpackage

`default_nettype wire

/* source/result_bus_if.sv */
`timescale 1ns/1ps
`default_nettype none

// pending register write of one stage, seen by forwarding and hazard logic
interface result_bus_if;
  import rv_pkg::*;

  logic      reg_write;
  reg_addr_t rd;
  word_t     data;
  logic      is_load; // data is not yet the loaded value in memory stage

  modport source (output reg_write, rd, data, is_load);
  modport sink   (input  reg_write, rd, data, is_load);

endinterface

`default_nettype wire

/* source/pipe_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     hold,   // keep current payload
  input  logic     bubble, // insert an all-zero payload
  input  payload_t d,
  output payload_t q
);

  always_ff @(posedge clk) begin
    if (reset || bubble) begin // bubble beats hold
      q <= '0;
    end else if (!hold) begin
      q <= d;
    end
  end

endmodule

`default_nettype wire

/* source/fetch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
  input  logic           clk,
  input  logic           reset,
  input  logic           hold,
  input  logic           redirect,
  input  rv_pkg::word_t  redirect_pc,
  output rv_pkg::word_t  imem_addr,
  input  rv_pkg::word_t  imem_data,
  output rv_pkg::if_id_t if_out
);
  import rv_pkg::*;

  word_t pc;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
    end else if (hold) begin // stall or halt freeze
      pc <= pc;
    end else if (redirect) begin // taken transfer resolved in execute
      pc <= redirect_pc;
    end else begin
      pc <= pc + 32'd4;
    end
  end

  assign imem_addr = pc; // memory answers in the same cycle
  assign if_out    = '{pc: pc, instr: imem_data};

  // branch and jump offsets from execute must keep the fetch address aligned
  a_pc_aligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
    else $error("fetch pc misaligned: %h", pc);

endmodule

`default_nettype wire

/* source/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_file (
  input  logic              clk,
  input  logic              reset,
  input  rv_pkg::reg_addr_t rs1,
  input  rv_pkg::reg_addr_t rs2,
  output rv_pkg::word_t     rs1_data,
  output rv_pkg::word_t     rs2_data,
  result_bus_if.sink        wb
);
  import rv_pkg::*;

  word_t regs [1:31]; // x0 has no storage

  always_ff @(posedge clk) begin
    if (wb.reg_write && wb.rd != '0) begin
      regs[wb.rd] <= wb.data;
    end
  end

  // write-through so decode sees the value retiring this cycle
  assign rs1_data = (rs1 == '0) ? '0 :
                    (wb.reg_write && wb.rd == rs1) ? wb.data : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 :
                    (wb.reg_write && wb.rd == rs2) ? wb.data : regs[rs2];

  // decode drops reg_write for rd 0, so no such write reaches writeback
  a_no_x0_write: assert property (@(posedge clk) disable iff (reset)
    !(wb.reg_write && wb.rd == '0))
    else $error("write to x0 reached writeback");

endmodule

`default_nettype wire

/* source/decode_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
  input  logic              clk,
  input  logic              reset,
  input  rv_pkg::if_id_t    id_in,
  result_bus_if.sink        wb,
  output rv_pkg::id_ex_t    id_out,
  output rv_pkg::reg_addr_t rs1,
  output rv_pkg::reg_addr_t rs2,
  output logic              is_ecall
);
  import rv_pkg::*;

  word_t      instr;
  logic [6:0] opcode;
  logic [2:0] funct3;
  reg_addr_t  rd;
  word_t      rs1_data;
  word_t      rs2_data;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_j;
  word_t      imm;
  ctrl_t      ctrl;
  alu_op_e    alu_op;

  // funct3 and bit 30 to alu op, shared by reg and imm forms
  function automatic alu_op_e alu_decode(logic [2:0] f3, logic alt);
    case (f3)
      3'b000:  return alt ? alu_sub : alu_add;
      3'b001:  return alu_sll;
      3'b010:  return alu_slt;
      3'b100:  return alu_xor;
      3'b101:  return alt ? alu_sra : alu_srl;
      3'b110:  return alu_or;
      3'b111:  return alu_and;
      default: return alu_add; // sltu not supported
    endcase
  endfunction

  assign instr    = id_in.instr;
  assign opcode   = instr[6:0];
  assign funct3   = instr[14:12];
  assign rd       = instr[11:7];
  assign is_ecall = (opcode == op_system) && (instr[31:7] == '0);
  assign rs1      = is_ecall ? halt_reg : instr[19:15]; // ecall reads a7
  assign rs2      = instr[24:20];

  reg_file rf (
    .clk      (clk),
    .reset    (reset),
    .rs1      (rs1),
    .rs2      (rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wb       (wb)
  );

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    ctrl   = '0;
    alu_op = alu_add;
    imm    = imm_i;
    case (opcode)
      op_reg: begin
        ctrl.reg_write = 1'b1;
        alu_op         = alu_decode(funct3, instr[30]);
      end
      op_imm: begin
        ctrl.reg_write   = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        alu_op           = (funct3 == 3'b000) ? alu_add : alu_decode(funct3, instr[30]);
      end
      op_load: begin
        ctrl.reg_write   = 1'b1;
        ctrl.mem_read    = 1'b1;
        ctrl.alu_src_imm = 1'b1; // address = rs1 + imm
      end
      op_store: begin
        ctrl.mem_write   = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        imm              = imm_s;
      end
      op_branch: begin
        ctrl.is_branch = 1'b1;
        imm            = imm_b;
      end
      op_jal: begin
        ctrl.reg_write = 1'b1;
        ctrl.is_jal    = 1'b1;
        ctrl.link      = 1'b1;
        imm            = imm_j;
      end
      op_jalr: begin
        ctrl.reg_write = 1'b1;
        ctrl.is_jalr   = 1'b1;
        ctrl.link      = 1'b1;
      end
      op_system: ctrl.halt = is_ecall && (rs1_data == halt_code);
      default: ; // unknown and bubble are no-ops
    endcase
    if (rd == '0) begin
      ctrl.reg_write = 1'b0; // x0 never written
    end
  end

  assign id_out = '{
    ctrl:     ctrl,
    alu_op:   alu_op,
    funct3:   funct3,
    pc:       id_in.pc,
    rs1_data: rs1_data,
    rs2_data: rs2_data,
    imm:      imm,
    rs1:      rs1,
    rs2:      rs2,
    rd:       rd
  };

endmodule

`default_nettype wire

/* source/hazard_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module hazard_unit (
  input  logic              clk,
  input  logic              reset,
  input  rv_pkg::reg_addr_t id_rs1,
  input  rv_pkg::reg_addr_t id_rs2,
  input  logic              id_is_ecall,
  input  rv_pkg::reg_addr_t ex_rd,
  input  logic              ex_reg_write,
  input  logic              ex_mem_read,
  result_bus_if.sink        mem_bus,
  result_bus_if.sink        wb_bus,
  input  logic              wb_halt,
  input  logic              redirect,
  output logic              pc_hold,
  output logic              if_id_hold,
  output logic              if_id_bubble,
  output logic              id_ex_bubble,
  output logic              pipe_hold,
  output logic              is_halted
);
  import rv_pkg::*;

  logic load_use;
  logic ecall_wait;
  logic stall;
  logic halted;

  assign load_use   = ex_mem_read && ex_rd != '0 && (ex_rd == id_rs1 || ex_rd == id_rs2);
  // writeback is covered by the register file bypass
  assign ecall_wait = id_is_ecall && ((ex_reg_write && ex_rd == halt_reg) ||
                                      (mem_bus.reg_write && mem_bus.rd == halt_reg));
  assign stall      = (load_use || ecall_wait) && !redirect; // flush wins

  always_ff @(posedge clk) begin
    if (reset) begin
      halted <= 1'b0;
    end else if (wb_halt) begin // sticky until reset
      halted <= 1'b1;
    end
  end

  assign pc_hold      = stall || halted;
  assign if_id_hold   = stall || halted;
  assign if_id_bubble = redirect && !halted;
  assign id_ex_bubble = (stall || redirect) && !halted;
  assign pipe_hold    = halted;
  assign is_halted    = halted;

  // the stalled load moves on with a bubble behind it in execute
  a_load_bubble: assert property (@(posedge clk) disable iff (reset || halted)
    load_use |=> mem_bus.is_load && !ex_reg_write && !ex_mem_read && ex_rd == '0
                 ##1 wb_bus.is_load)
    else $error("load-use stall did not put a bubble behind the load");

endmodule

`default_nettype wire

/* source/execute_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
  input  rv_pkg::id_ex_t  ex_in,
  result_bus_if.sink      mem_bus,
  result_bus_if.sink      wb_bus,
  output rv_pkg::ex_mem_t ex_out,
  output logic            redirect,
  output rv_pkg::word_t   redirect_pc
);
  import rv_pkg::*;

  word_t op_a;
  word_t op_b;
  word_t alu_b;
  word_t alu_res;
  word_t jalr_sum;
  logic  cond;

  // memory stage is younger, so it takes priority over writeback
  always_comb begin
    op_a = ex_in.rs1_data;
    if (mem_bus.reg_write && mem_bus.rd != '0 && mem_bus.rd == ex_in.rs1) begin
      op_a = mem_bus.data;
    end else if (wb_bus.reg_write && wb_bus.rd != '0 && wb_bus.rd == ex_in.rs1) begin
      op_a = wb_bus.data;
    end
  end

  always_comb begin
    op_b = ex_in.rs2_data;
    if (mem_bus.reg_write && mem_bus.rd != '0 && mem_bus.rd == ex_in.rs2) begin
      op_b = mem_bus.data;
    end else if (wb_bus.reg_write && wb_bus.rd != '0 && wb_bus.rd == ex_in.rs2) begin
      op_b = wb_bus.data;
    end
  end

  assign alu_b = ex_in.ctrl.alu_src_imm ? ex_in.imm : op_b;

  always_comb begin
    case (ex_in.alu_op)
      alu_sub: alu_res = op_a - alu_b;
      alu_and: alu_res = op_a & alu_b;
      alu_or:  alu_res = op_a | alu_b;
      alu_xor: alu_res = op_a ^ alu_b;
      alu_sll: alu_res = op_a << alu_b[4:0];
      alu_srl: alu_res = op_a >> alu_b[4:0];
      alu_sra: alu_res = $signed(op_a) >>> alu_b[4:0];
      alu_slt: alu_res = {31'd0, $signed(op_a) < $signed(alu_b)};
      default: alu_res = op_a + alu_b;
    endcase
  end

  always_comb begin
    case (ex_in.funct3)
      3'b000:  cond = op_a == op_b;                   // beq
      3'b001:  cond = op_a != op_b;                   // bne
      3'b100:  cond = $signed(op_a) < $signed(op_b);  // blt
      3'b101:  cond = $signed(op_a) >= $signed(op_b); // bge
      default: cond = 1'b0;
    endcase
  end

  // predicted not-taken, so any transfer here redirects fetch
  assign redirect    = (ex_in.ctrl.is_branch && cond) || ex_in.ctrl.is_jal || ex_in.ctrl.is_jalr;
  assign jalr_sum    = op_a + ex_in.imm;
  assign redirect_pc = ex_in.ctrl.is_jalr ? {jalr_sum[31:1], 1'b0} : ex_in.pc + ex_in.imm;

  assign ex_out = '{
    reg_write:  ex_in.ctrl.reg_write,
    mem_read:   ex_in.ctrl.mem_read,
    mem_write:  ex_in.ctrl.mem_write,
    halt:       ex_in.ctrl.halt,
    result:     ex_in.ctrl.link ? ex_in.pc + 32'd4 : alu_res,
    store_data: op_b, // forwarded rs2
    rd:         ex_in.rd
  };

endmodule

`default_nettype wire

/* source/memory_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module memory_stage (
  input  logic            clk,
  input  logic            reset,
  input  logic            hold,
  input  rv_pkg::ex_mem_t mem_in,
  output rv_pkg::word_t   dmem_addr,
  output rv_pkg::word_t   dmem_wdata,
  output logic            dmem_write,
  output logic            dmem_read,
  input  rv_pkg::word_t   dmem_rdata,
  result_bus_if.source    mem_bus,
  result_bus_if.source    wb_bus,
  output logic            wb_halt
);
  import rv_pkg::*;

  mem_wb_t wb_d;
  mem_wb_t wb_q;
  logic    wb_is_load;

  assign dmem_addr  = mem_in.result;
  assign dmem_wdata = mem_in.store_data;
  assign dmem_write = mem_in.mem_write && !hold; // no repeat strobe once frozen
  assign dmem_read  = mem_in.mem_read && !hold;

  assign wb_d = '{
    reg_write: mem_in.reg_write,
    halt:      mem_in.halt,
    wdata:     mem_in.mem_read ? dmem_rdata : mem_in.result,
    rd:        mem_in.rd
  };

  pipe_reg #(.payload_t(mem_wb_t)) mem_wb_reg (
    .clk    (clk),
    .reset  (reset),
    .hold   (hold),
    .bubble (1'b0),
    .d      (wb_d),
    .q      (wb_q)
  );

  always_ff @(posedge clk) begin
    if (reset) begin
      wb_is_load <= 1'b0;
    end else if (!hold) begin // tracks mem_wb_reg
      wb_is_load <= mem_in.mem_read;
    end
  end

  assign mem_bus.reg_write = mem_in.reg_write;
  assign mem_bus.rd        = mem_in.rd;
  assign mem_bus.data      = mem_in.result; // alu or link value
  assign mem_bus.is_load   = mem_in.mem_read;

  assign wb_bus.reg_write = wb_q.reg_write;
  assign wb_bus.rd        = wb_q.rd;
  assign wb_bus.data      = wb_q.wdata;
  assign wb_bus.is_load   = wb_is_load;
  assign wb_halt          = wb_q.halt;

  a_one_strobe: assert property (@(posedge clk) disable iff (reset) !(dmem_write && dmem_read))
    else $error("dmem read and write strobes together");

endmodule

`default_nettype wire

/* source/cpu_core.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_core (
  input  logic          clk,
  input  logic          reset,
  output rv_pkg::word_t imem_addr,
  input  rv_pkg::word_t imem_data,
  output rv_pkg::word_t dmem_addr,
  output rv_pkg::word_t dmem_wdata,
  output logic          dmem_write,
  output logic          dmem_read,
  input  rv_pkg::word_t dmem_rdata,
  output logic          is_halted
);
  import rv_pkg::*;

  if_id_t    if_d;
  if_id_t    if_q;
  id_ex_t    id_d;
  id_ex_t    id_q;
  ex_mem_t   ex_d;
  ex_mem_t   ex_q;
  reg_addr_t id_rs1;
  reg_addr_t id_rs2;
  logic      id_is_ecall;
  logic      redirect;
  word_t     redirect_pc;
  logic      pc_hold;
  logic      if_id_hold;
  logic      if_id_bubble;
  logic      id_ex_bubble;
  logic      pipe_hold;
  logic      wb_halt;

  result_bus_if mem_bus ();
  result_bus_if wb_bus ();

  fetch_unit fetch (
    .clk, .reset, .hold(pc_hold), .redirect, .redirect_pc,
    .imem_addr, .imem_data, .if_out(if_d)
  );

  pipe_reg #(.payload_t(if_id_t)) if_id_reg (
    .clk, .reset, .hold(if_id_hold), .bubble(if_id_bubble), .d(if_d), .q(if_q)
  );

  decode_stage decode (
    .clk, .reset, .id_in(if_q), .wb(wb_bus), .id_out(id_d),
    .rs1(id_rs1), .rs2(id_rs2), .is_ecall(id_is_ecall)
  );

  pipe_reg #(.payload_t(id_ex_t)) id_ex_reg (
    .clk, .reset, .hold(pipe_hold), .bubble(id_ex_bubble), .d(id_d), .q(id_q)
  );

  execute_stage execute (
    .ex_in(id_q), .mem_bus, .wb_bus, .ex_out(ex_d), .redirect, .redirect_pc
  );

  pipe_reg #(.payload_t(ex_mem_t)) ex_mem_reg (
    .clk, .reset, .hold(pipe_hold), .bubble(1'b0), .d(ex_d), .q(ex_q)
  );

  memory_stage memory (
    .clk, .reset, .hold(pipe_hold), .mem_in(ex_q),
    .dmem_addr, .dmem_wdata, .dmem_write, .dmem_read, .dmem_rdata,
    .mem_bus, .wb_bus, .wb_halt
  );

  hazard_unit hazard (
    .clk, .reset, .id_rs1, .id_rs2, .id_is_ecall,
    .ex_rd(id_q.rd), .ex_reg_write(id_q.ctrl.reg_write), .ex_mem_read(id_q.ctrl.mem_read),
    .mem_bus, .wb_bus, .wb_halt, .redirect,
    .pc_hold, .if_id_hold, .if_id_bubble, .id_ex_bubble, .pipe_hold, .is_halted
  );

endmodule

`default_nettype wire

/* test/cpu_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_core_tb;

  // rv32i base opcodes
  localparam logic [6:0]  opc_reg    = 7'b0110011;
  localparam logic [6:0]  opc_imm    = 7'b0010011;
  localparam logic [6:0]  opc_load   = 7'b0000011;
  localparam logic [6:0]  opc_store  = 7'b0100011;
  localparam logic [6:0]  opc_branch = 7'b1100011;
  localparam logic [6:0]  opc_jal    = 7'b1101111;
  localparam logic [6:0]  opc_jalr   = 7'b1100111;
  localparam logic [31:0] nop_word   = 32'h0000_0013; // addi x0, x0, 0
  localparam logic [31:0] ecall_word = 32'h0000_0073;
  localparam int          reset_cycles  = 8;
  localparam int          settle_cycles = 12; // watched after halt

  // {alt, funct3} per operation
  localparam logic [35:0] r_ops = {4'b0000, 4'b1000, 4'b0001, 4'b0010, 4'b0100,
                                   4'b0101, 4'b1101, 4'b0110, 4'b0111};
  localparam logic [31:0] i_ops = {4'b0000, 4'b0010, 4'b0100, 4'b0110,
                                   4'b0111, 4'b0001, 4'b0101, 4'b1101};

  logic        clk;
  logic        reset;
  logic [31:0] imem_addr;
  logic [31:0] imem_data;
  logic [31:0] dmem_addr;
  logic [31:0] dmem_wdata;
  logic        dmem_write;
  logic        dmem_read;
  logic [31:0] dmem_rdata;
  logic        is_halted;

  logic [31:0] imem [256];
  logic [31:0] dmem [256];
  logic [31:0] prog [$];     // program under construction
  logic [31:0] exp_addr [$]; // expected stores in program order
  logic [31:0] exp_data [$];
  logic [31:0] exp_load [$]; // expected load addresses
  logic [31:0] log_addr [$]; // observed stores
  logic [31:0] log_data [$];
  logic [31:0] log_load [$]; // observed load strobes
  int          late_writes;
  int          errors;
  int          checks;
  int          tests;
  int          cycle_budget = 40;
  int          cycle_count;
  logic [15:0] lfsr_state;

  cpu_core uut (
    .clk        (clk),
    .reset      (reset),
    .imem_addr  (imem_addr),
    .imem_data  (imem_data),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .dmem_write (dmem_write),
    .dmem_read  (dmem_read),
    .dmem_rdata (dmem_rdata),
    .is_halted  (is_halted)
  );

  assign imem_data  = imem[imem_addr[9:2]]; // combinational fetch
  assign dmem_rdata = dmem[dmem_addr[9:2]]; // combinational load

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // data memory write port and traffic log
  always @(posedge clk) begin
    if (dmem_write === 1'b1) begin
      dmem[dmem_addr[9:2]] <= dmem_wdata;
      log_addr.push_back(dmem_addr);
      log_data.push_back(dmem_wdata);
      if (is_halted === 1'b1) begin
        late_writes++;
      end
    end
    if (dmem_read === 1'b1) begin
      log_load.push_back(dmem_addr); // one entry per strobe cycle
    end
  end

  // backstop, budget grows as each test starts
  initial begin
    cycle_count = 0;
    while (cycle_count <= cycle_budget) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("ERROR: run did not finish within its limit of %0d cycles", cycle_budget);
    $display("STATUS: FAIL");
    $finish;
  end

  // galois form, taps x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
  endfunction

  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state); // one step per bit
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  function automatic int random_imm12();
    logic [11:0] r;
    r = random_bits(12);
    return $signed(r); // sign extended
  endfunction

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, opc_reg};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opc_store}; // sw only
  endfunction

  function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opc_branch};
  endfunction

  function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc_jal};
  endfunction

  // rv32i result rules
  function automatic logic [31:0] isa_alu(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    logic signed [31:0] sa;
    sa = a;
    case (f3)
      3'b000:  return alt ? a - b : a + b;
      3'b001:  return a << b[4:0];
      3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b100:  return a ^ b;
      3'b101: begin
        if (alt) begin
          return sa >>> b[4:0]; // sign fill
        end
        return a >> b[4:0];
      end
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                        input logic [31:0] b);
    case (f3)
      3'b000:  return a == b;
      3'b001:  return a != b;
      3'b100:  return $signed(a) < $signed(b);
      default: return $signed(a) >= $signed(b);
    endcase
  endfunction

  task automatic check(input string sig, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t: %s got %h expected %h", $time, sig, got, exp);
    end
  endtask

  task automatic emit(input logic [31:0] word);
    prog.push_back(word);
  endtask

  task automatic emit_addi(input logic [4:0] rd, input logic [4:0] rs1, input int imm);
    emit(i_type(12'(imm), rs1, 3'b000, rd, opc_imm));
  endtask

  task automatic emit_sw(input logic [4:0] rs2, input logic [4:0] rs1, input int off);
    emit(s_type(12'(off), rs2, rs1));
  endtask

  task automatic emit_lw(input logic [4:0] rd, input logic [4:0] rs1, input int off);
    emit(i_type(12'(off), rs1, 3'b010, rd, opc_load));
  endtask

  task automatic emit_halt();
    emit_addi(17, 0, 10); // exit request in a7
    emit(ecall_word);
    repeat (3) emit(nop_word); // younger slots are not cancelled
  endtask

  task automatic expect_store(input int addr, input logic [31:0] data);
    exp_addr.push_back(addr);
    exp_data.push_back(data);
  endtask

  task automatic expect_load(input int addr);
    exp_load.push_back(addr);
  endtask

  task automatic new_program();
    prog.delete();
    exp_addr.delete();
    exp_data.delete();
    exp_load.delete();
  endtask

  task automatic run_program(input string name);
    int limit;
    int cycles;
    limit = 4 * prog.size() + 20;
    cycle_budget += limit + reset_cycles + settle_cycles + 2;
    for (int i = 0; i < 256; i++) begin
      imem[i] = (i < prog.size()) ? prog[i] : 32'h0; // zero decodes as a no-op
      dmem[i] = 32'hda7a_0000 + i;
    end
    log_addr.delete();
    log_data.delete();
    log_load.delete();
    late_writes = 0;
    reset = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    #1 reset = 1'b0;
    cycles = 0;
    while (is_halted !== 1'b1 && cycles < limit) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (is_halted !== 1'b1) begin
      errors++;
      $display("ERROR at %0t: core never halted in test %s within %0d cycles",
               $time, name, limit);
    end
  endtask

  task automatic compare_stores();
    int n;
    check("store count", log_addr.size(), exp_addr.size());
    n = (log_addr.size() < exp_addr.size()) ? log_addr.size() : exp_addr.size();
    for (int i = 0; i < n; i++) begin
      check($sformatf("dmem_addr[%0d]", i), log_addr[i], exp_addr[i]);
      check($sformatf("dmem_wdata[%0d]", i), log_data[i], exp_data[i]);
    end
  endtask

  task automatic compare_loads();
    int n;
    check("dmem_read count", log_load.size(), exp_load.size());
    n = (log_load.size() < exp_load.size()) ? log_load.size() : exp_load.size();
    for (int i = 0; i < n; i++) begin
      check($sformatf("dmem_read addr[%0d]", i), log_load[i], exp_load[i]);
    end
  endtask

  task automatic report_test(input string name, input int err0);
    tests++;
    if (errors == err0) begin
      $display("test %-12s ok", name);
    end else begin
      $display("test %-12s %0d errors", name, errors - err0);
    end
  endtask

  task automatic test_alu();
    int          err0;
    int          base;
    int          a;
    int          b;
    int          imm;
    logic [3:0]  op;
    logic [31:0] opb;
    err0 = errors;
    new_program();
    for (int round = 0; round < 2; round++) begin
      a    = random_imm12();
      b    = random_imm12();
      base = 'h200 + round * 'h80;
      emit_addi(1, 0, a);
      emit_addi(2, 0, b);
      for (int k = 0; k < 9; k++) begin
        op = r_ops[4*k +: 4];
        emit(r_type(op[3] ? 7'b0100000 : 7'b0000000, 2, 1, op[2:0], 3));
        emit_sw(3, 0, base + 4*k);
        expect_store(base + 4*k, isa_alu(op[2:0], op[3], a, b));
      end
      for (int k = 0; k < 8; k++) begin
        op = i_ops[4*k +: 4];
        if (op[1:0] == 2'b01) begin // slli, srli, srai take a shamt
          opb = random_bits(5);
          imm = (op[3] ? 'h400 : 0) + opb;
        end else begin
          imm = random_imm12();
          opb = imm;
        end
        emit(i_type(12'(imm), 1, op[2:0], 3, opc_imm));
        emit_sw(3, 0, base + 36 + 4*k);
        expect_store(base + 36 + 4*k, isa_alu(op[2:0], op[3] && op[2:0] == 3'b101, a, opb));
      end
    end
    emit_halt();
    run_program("alu");
    compare_stores();
    compare_loads();
    report_test("alu", err0);
  endtask

  task automatic test_forwarding();
    int          err0;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] v [1:8];
    err0 = errors;
    new_program();
    a = random_imm12();
    b = random_imm12();
    v[1] = a;
    v[2] = v[1] + b;
    v[3] = v[2] + v[1];
    v[4] = v[3] + v[2];
    v[5] = v[4] + v[3];
    v[6] = v[5] + v[4];
    v[7] = v[6] - v[1];
    v[8] = a + b + b;
    emit_addi(1, 0, a);
    emit_addi(2, 1, b);                // x1 from memory
    emit(r_type(7'd0, 1, 2, 3'b000, 3)); // x2 memory, x1 writeback
    emit_sw(3, 0, 'h300);              // store data from memory
    emit(r_type(7'd0, 2, 3, 3'b000, 4));
    emit(nop_word);
    emit(r_type(7'd0, 3, 4, 3'b000, 5)); // distance two
    emit(nop_word);
    emit(nop_word);
    emit(r_type(7'd0, 4, 5, 3'b000, 6)); // through the register file
    emit(r_type(7'b0100000, 1, 6, 3'b000, 7));
    emit_sw(7, 0, 'h304);
    emit_sw(6, 0, 'h308);
    emit_sw(5, 0, 'h30c);
    emit_sw(4, 0, 'h310);
    emit_sw(2, 0, 'h314);
    emit_addi(8, 0, a);
    emit_addi(8, 8, b); // memory copy must beat writeback copy
    emit_addi(8, 8, b);
    emit_sw(8, 0, 'h318);
    emit_halt();
    expect_store('h300, v[3]);
    expect_store('h304, v[7]);
    expect_store('h308, v[6]);
    expect_store('h30c, v[5]);
    expect_store('h310, v[4]);
    expect_store('h314, v[2]);
    expect_store('h318, v[8]);
    run_program("forwarding");
    compare_stores();
    compare_loads();
    report_test("forwarding", err0);
  endtask

  task automatic test_load_use();
    int          err0;
    logic [31:0] val;
    logic [31:0] fill;
    err0 = errors;
    new_program();
    val  = random_imm12();
    fill = 32'hda7a_0000 + 'h20; // untouched word at 0x80
    emit_addi(5, 0, val);
    emit_sw(5, 0, 'h40);
    emit_lw(6, 0, 'h40);
    emit_addi(7, 6, 1);  // needs the load at once
    emit_sw(7, 0, 'h44);
    emit_lw(0, 0, 'h40); // discarded
    emit_sw(0, 0, 'h48);
    emit_lw(9, 0, 'h40);
    emit_sw(9, 0, 'h4c); // load feeds store data
    emit_lw(11, 0, 'h80);
    emit(nop_word);
    emit(r_type(7'd0, 5, 11, 3'b000, 12));
    emit_sw(12, 0, 'h50);
    emit_sw(11, 0, 'h54);
    emit_halt();
    expect_store('h40, val);
    expect_store('h44, val + 1);
    expect_store('h48, 32'd0);
    expect_store('h4c, val);
    expect_store('h50, fill + val);
    expect_store('h54, fill);
    expect_load('h40);
    expect_load('h40);
    expect_load('h40);
    expect_load('h80);
    run_program("load_use");
    compare_stores();
    compare_loads();
    report_test("load_use", err0);
  endtask

  // branch over one marker store
  task automatic emit_branch_case(input logic [2:0] f3, input logic [4:0] rs1,
                                  input logic [4:0] rs2, input logic [31:0] va,
                                  input logic [31:0] vb, input int addr);
    emit(b_type(13'd8, rs2, rs1, f3));
    emit_sw(4, 0, addr);
    if (!branch_taken(f3, va, vb)) begin
      expect_store(addr, 32'h77);
    end
  endtask

  task automatic test_control();
    int          err0;
    int          pc;
    logic [31:0] five;
    logic [31:0] neg;
    err0 = errors;
    new_program();
    five = 32'd5;
    neg  = -32'sd3;
    emit_addi(1, 0, 5);
    emit_addi(2, 0, 5);
    emit_addi(3, 0, -3);
    emit_addi(4, 0, 'h77); // marker value
    emit_branch_case(3'b000, 1, 2, five, five, 'h100); // beq
    emit_branch_case(3'b000, 1, 3, five, neg,  'h104);
    emit_branch_case(3'b001, 1, 3, five, neg,  'h108); // bne
    emit_branch_case(3'b001, 1, 2, five, five, 'h10c);
    emit_branch_case(3'b100, 3, 1, neg,  five, 'h110); // blt, signed
    emit_branch_case(3'b100, 1, 3, five, neg,  'h114);
    emit_branch_case(3'b101, 1, 3, five, neg,  'h118); // bge
    emit_branch_case(3'b101, 3, 1, neg,  five, 'h11c);
    emit_branch_case(3'b101, 1, 2, five, five, 'h120);
    pc = prog.size() * 4;
    emit(j_type(21'd12, 5)); // over two stores
    emit_sw(4, 0, 'h130);
    emit_sw(4, 0, 'h134);
    emit_sw(5, 0, 'h138);
    expect_store('h138, pc + 4);
    pc = prog.size() * 4;
    emit_addi(6, 0, pc + 11);
    emit(i_type(12'd6, 6, 3'b000, 7, opc_jalr)); // pc + 17, bit 0 cleared
    emit_sw(4, 0, 'h140);
    emit_sw(4, 0, 'h144);
    emit_sw(7, 0, 'h148);
    expect_store('h148, pc + 8);
    emit_halt();
    run_program("control");
    compare_stores();
    compare_loads();
    report_test("control", err0);
  endtask

  task automatic test_halt();
    int err0;
    err0 = errors;
    new_program();
    emit_addi(17, 0, 5);
    emit(ecall_word); // not an exit request
    emit_sw(17, 0, 'h180);
    emit_addi(4, 0, 'h55);
    emit_sw(4, 0, 'h184);
    emit_halt();
    emit_sw(4, 0, 'h188); // fetched but frozen in decode
    expect_store('h180, 32'd5);
    expect_store('h184, 32'h55);
    run_program("halt");
    for (int i = 0; i < settle_cycles; i++) begin
      @(posedge clk);
      #1;
      check("is_halted", is_halted, 1'b1);
    end
    check("dmem_write after halt", late_writes, 0);
    compare_stores();
    compare_loads();
    report_test("halt", err0);
  endtask

  initial begin
    reset       = 1'b1;
    lfsr_state  = 16'd69;
    errors      = 0;
    checks      = 0;
    tests       = 0;
    late_writes = 0;
    test_alu();
    test_forwarding();
    test_load_use();
    test_control();
    test_halt();
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* cpu_core.f */
source/rv_pkg.sv
source/result_bus_if.sv
source/pipe_reg.sv
source/fetch_unit.sv
source/reg_file.sv
source/decode_stage.sv
source/hazard_unit.sv
source/execute_stage.sv
source/memory_stage.sv
source/cpu_core.sv
test/cpu_core_tb.sv

/* Bender.yml */
package:
  name: cpu_core

sources:
  - source/rv_pkg.sv
  - source/result_bus_if.sv
  - source/pipe_reg.sv
  - source/fetch_unit.sv
  - source/reg_file.sv
  - source/decode_stage.sv
  - source/hazard_unit.sv
  - source/execute_stage.sv
  - source/memory_stage.sv
  - source/cpu_core.sv
  - target: test
    files:
      - test/cpu_core_tb.sv
